/* src/vcore_netif_cfg.svh */
// vcore network interface configuration
`ifndef VCORE_NETIF_CFG_SVH
`define VCORE_NETIF_CFG_SVH

// word and packet address widths
`define VNI_DATA_WIDTH 32
`define VNI_ADDR_WIDTH 28

// mesh coordinates
`define VNI_X_CORD_WIDTH 6
`define VNI_Y_CORD_WIDTH 5
// coordinate fields inside a global eva
`define VNI_GLOBAL_CORD_WIDTH 6

`define VNI_LOAD_ID_WIDTH 12
`define VNI_DRAM_CH_ADDR_WIDTH 25
`define VNI_EPA_WORD_ADDR_WIDTH 16

// send credits
`define VNI_MAX_OUT_CREDITS 16

// queue depths
`define VNI_REQ_FIFO_DEPTH 4
`define VNI_RESP_FIFO_DEPTH 4

`endif

/* src/vcore_netif_pkg.sv */
// vcore network interface types
`default_nettype none

`include "vcore_netif_cfg.svh"

package vcore_netif_pkg;

  typedef enum logic [1:0] {
    e_remote_load    = 2'b00,
    e_remote_store   = 2'b01,
    e_remote_swap_aq = 2'b10,
    e_remote_swap_rl = 2'b11
  } packet_op_e;

  typedef logic [$clog2(`VNI_MAX_OUT_CREDITS + 1)-1:0] credit_cnt_t;

  // effective address views
  typedef struct packed {
    logic                               is_dram;
    logic [`VNI_X_CORD_WIDTH-1:0]       x_cord;
    logic [`VNI_DRAM_CH_ADDR_WIDTH-1:0] addr;
  } eva_dram_s;

  typedef struct packed {
    logic [1:0]                          remote;
    logic [`VNI_GLOBAL_CORD_WIDTH-1:0]   y_cord;
    logic [`VNI_GLOBAL_CORD_WIDTH-1:0]   x_cord;
    logic [`VNI_EPA_WORD_ADDR_WIDTH-1:0] addr;
    logic [1:0]                          low_bits;
  } eva_global_s;

  typedef struct packed {
    logic [2:0]                          remote;
    logic [`VNI_Y_CORD_WIDTH-1:0]        y_cord;
    logic [`VNI_X_CORD_WIDTH-1:0]        x_cord;
    logic [`VNI_EPA_WORD_ADDR_WIDTH-1:0] addr;
    logic [1:0]                          low_bits;
  } eva_in_group_s;

  // travels as the load id and comes back with the data
  typedef struct packed {
    logic       float_wb;
    logic       icache_fetch;
    logic       is_unsigned_op;
    logic       is_byte_op;
    logic       is_hex_op;
    logic [1:0] part_sel;
    logic [4:0] reg_id;
  } load_info_s;

  typedef struct packed {
    logic                       write_not_read;
    logic                       swap_aq;
    logic                       swap_rl;
    logic [3:0]                 mask;
    logic [31:0]                addr;
    logic [`VNI_DATA_WIDTH-1:0] payload;
  } remote_req_s;

  typedef struct packed {
    logic [`VNI_ADDR_WIDTH-1:0]   addr;
    packet_op_e                   op;
    logic [3:0]                   op_ex;
    logic [`VNI_DATA_WIDTH-1:0]   payload;
    logic [`VNI_Y_CORD_WIDTH-1:0] src_y_cord;
    logic [`VNI_X_CORD_WIDTH-1:0] src_x_cord;
    logic [`VNI_Y_CORD_WIDTH-1:0] y_cord;
    logic [`VNI_X_CORD_WIDTH-1:0] x_cord;
  } netif_packet_s;

  typedef struct packed {
    logic [`VNI_DATA_WIDTH-1:0]    data;
    logic [`VNI_LOAD_ID_WIDTH-1:0] load_id;
  } returned_resp_s;

  typedef struct packed {
    logic [4:0]                 rd;
    logic [`VNI_DATA_WIDTH-1:0] data;
  } load_resp_s;

endpackage

`default_nettype wire

/* src/netif_fifo.sv */
// small synchronous fifo
`timescale 1ns/10ps
`default_nettype none

module netif_fifo #(
  parameter type payload_t = logic,
  parameter int  depth_p   = 4
) (
  input  wire      clk_i,
  input  wire      reset_i,
  input  wire      v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  wire      yumi_i,
  output logic     full_o
);

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  payload_t                mem [depth_p];
  payload_t                head_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_n;
  logic [cnt_width_lp-1:0] count_r;
  logic                    push;
  logic                    pop;

  function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] p);
    return (p == ptr_width_lp'(depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full_o  = (count_r == cnt_width_lp'(depth_p));
  assign ready_o = ~full_o;
  assign v_o     = (count_r != '0);
  assign data_o  = head_r;

  assign push     = v_i & ready_o;
  assign pop      = yumi_i;
  assign rd_ptr_n = pop ? ptr_inc(rd_ptr_r) : rd_ptr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      rd_ptr_r <= rd_ptr_n;
      if (push) wr_ptr_r <= ptr_inc(wr_ptr_r);
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // storage and registered head with write bypass
  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_r] <= data_i;
    head_r <= (push && (wr_ptr_r == rd_ptr_n)) ? data_i : mem[rd_ptr_n];
  end

  // consumer must only pop a valid head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

/* src/credit_counter.sv */
// send credit counter
`timescale 1ns/10ps
`default_nettype none

`include "vcore_netif_cfg.svh"

module credit_counter import vcore_netif_pkg::*; (
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire         spend_i,
  input  wire         return_i,
  output credit_cnt_t credits_o
);

  credit_cnt_t credits_r;

  assign credits_o = credits_r;

  // spend and return together leave the count alone
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= credit_cnt_t'(`VNI_MAX_OUT_CREDITS);
    end else if (spend_i && !return_i) begin
      credits_r <= credits_r - 1'b1;
    end else if (return_i && !spend_i) begin
      credits_r <= credits_r + 1'b1;
    end
  end

  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (spend_i && !return_i) |-> (credits_r != '0));

  // network returns no more credits than were spent
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (return_i && !spend_i) |-> (credits_r != credit_cnt_t'(`VNI_MAX_OUT_CREDITS)));

endmodule

`default_nettype wire

/* src/load_packer.sv */
// integer load data packer
`timescale 1ns/10ps
`default_nettype none

`include "vcore_netif_cfg.svh"

module load_packer (
  input  wire  [`VNI_DATA_WIDTH-1:0] mem_data_i,
  input  wire                        unsigned_load_i,
  input  wire                        byte_load_i,
  input  wire                        hex_load_i,
  input  wire  [1:0]                 part_sel_i,
  output logic [`VNI_DATA_WIDTH-1:0] load_data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign byte_sel = mem_data_i[8*part_sel_i +: 8];
  // halfword picked by the upper select bit
  assign half_sel = part_sel_i[1] ? mem_data_i[31:16] : mem_data_i[15:0];

  always_comb begin
    if (byte_load_i) begin
      load_data_o = {{(`VNI_DATA_WIDTH-8){~unsigned_load_i & byte_sel[7]}}, byte_sel};
    end else if (hex_load_i) begin
      load_data_o = {{(`VNI_DATA_WIDTH-16){~unsigned_load_i & half_sel[15]}}, half_sel};
    end else begin
      // full word
      load_data_o = mem_data_i;
    end
  end

endmodule

`default_nettype wire

/* src/network_tx.sv */
// request translation and response dispatch
`timescale 1ns/10ps
`default_nettype none

`include "vcore_netif_cfg.svh"

module network_tx import vcore_netif_pkg::*; (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire                          req_v_i,
  input  remote_req_s                  req_i,
  output logic                         req_yumi_o,
  output netif_packet_s                out_packet_o,
  output logic                         out_v_o,
  input  wire                          out_ready_i,
  input  credit_cnt_t                  credits_i,
  input  wire  [`VNI_X_CORD_WIDTH-1:0] tgo_x_i,
  input  wire  [`VNI_Y_CORD_WIDTH-1:0] tgo_y_i,
  input  wire  [`VNI_X_CORD_WIDTH-1:0] my_x_i,
  input  wire  [`VNI_Y_CORD_WIDTH-1:0] my_y_i,
  input  wire                          resp_v_i,
  input  returned_resp_s               resp_i,
  input  wire                          resp_full_i,
  output logic                         resp_yumi_o,
  output logic                         ifetch_v_o,
  output logic [`VNI_DATA_WIDTH-1:0]   ifetch_instr_o,
  output logic                         float_resp_v_o,
  output load_resp_s                   float_resp_o,
  output logic                         int_resp_v_o,
  output load_resp_s                   int_resp_o,
  output logic                         int_resp_force_o,
  input  wire                          int_resp_yumi_i
);

  eva_dram_s     dram_eva;
  eva_global_s   global_eva;
  eva_in_group_s group_eva;
  logic          is_dram;
  logic          is_global;
  logic          is_in_group;
  load_info_s    load_info;
  logic [`VNI_DATA_WIDTH-1:0] int_data;

  assign dram_eva    = req_i.addr;
  assign global_eva  = req_i.addr;
  assign group_eva   = req_i.addr;
  assign is_dram     = dram_eva.is_dram;
  assign is_global   = (global_eva.remote == 2'b01);
  assign is_in_group = (group_eva.remote == 3'b001);

  always_comb begin
    out_packet_o.op_ex      = req_i.mask;
    out_packet_o.payload    = req_i.payload;
    out_packet_o.src_y_cord = my_y_i;
    out_packet_o.src_x_cord = my_x_i;
    // swaps take priority over plain stores
    if (req_i.swap_aq)             out_packet_o.op = e_remote_swap_aq;
    else if (req_i.swap_rl)        out_packet_o.op = e_remote_swap_rl;
    else if (req_i.write_not_read) out_packet_o.op = e_remote_store;
    else                           out_packet_o.op = e_remote_load;

    if (is_dram) begin
      out_packet_o.y_cord = '1;
      out_packet_o.x_cord = dram_eva.x_cord;
      out_packet_o.addr   = `VNI_ADDR_WIDTH'(dram_eva.addr);
    end else if (is_global) begin
      out_packet_o.y_cord = `VNI_Y_CORD_WIDTH'(global_eva.y_cord);
      out_packet_o.x_cord = `VNI_X_CORD_WIDTH'(global_eva.x_cord);
      out_packet_o.addr   = `VNI_ADDR_WIDTH'(global_eva.addr);
    end else if (is_in_group) begin
      // group origin offset, wraps in the mesh
      out_packet_o.y_cord = `VNI_Y_CORD_WIDTH'(group_eva.y_cord + tgo_y_i);
      out_packet_o.x_cord = `VNI_X_CORD_WIDTH'(group_eva.x_cord + tgo_x_i);
      out_packet_o.addr   = `VNI_ADDR_WIDTH'(group_eva.addr);
    end else begin
      out_packet_o.y_cord = '0;
      out_packet_o.x_cord = '0;
      out_packet_o.addr   = '0;
    end
  end

  // send only with credit left
  assign out_v_o    = req_v_i & (credits_i != '0);
  assign req_yumi_o = out_v_o & out_ready_i;

  assign load_info = resp_i.load_id;

  load_packer u_load_packer (
    .mem_data_i      (resp_i.data),
    .unsigned_load_i (load_info.is_unsigned_op),
    .byte_load_i     (load_info.is_byte_op),
    .hex_load_i      (load_info.is_hex_op),
    .part_sel_i      (load_info.part_sel),
    .load_data_o     (int_data)
  );

  assign ifetch_instr_o    = resp_i.data;
  assign float_resp_o.rd   = load_info.reg_id;
  assign float_resp_o.data = resp_i.data;
  assign int_resp_o.rd     = load_info.reg_id;
  assign int_resp_o.data   = int_data;

  always_comb begin
    ifetch_v_o       = 1'b0;
    float_resp_v_o   = 1'b0;
    int_resp_v_o     = 1'b0;
    int_resp_force_o = 1'b0;
    if (load_info.icache_fetch) begin
      ifetch_v_o  = resp_v_i;
      resp_yumi_o = resp_v_i;
    end else if (load_info.float_wb) begin
      float_resp_v_o = resp_v_i;
      resp_yumi_o    = resp_v_i;
    end else begin
      // full queue forces the integer head out
      int_resp_v_o     = resp_v_i;
      int_resp_force_o = resp_v_i & resp_full_i;
      resp_yumi_o      = resp_v_i & (int_resp_yumi_i | resp_full_i);
    end
  end

  a_valid_eva: assert property (@(posedge clk_i) disable iff (reset_i)
    out_v_o |-> (is_dram || is_global || is_in_group));

endmodule

`default_nettype wire

/* src/vcore_netif.sv */
// vcore network interface top
`timescale 1ns/10ps
`default_nettype none

`include "vcore_netif_cfg.svh"

module vcore_netif import vcore_netif_pkg::*; (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire                          remote_req_v_i,
  input  remote_req_s                  remote_req_i,
  output logic                         remote_req_yumi_o,
  output netif_packet_s                out_packet_o,
  output logic                         out_v_o,
  input  wire                          out_ready_i,
  input  wire                          out_credit_v_i,
  input  wire                          returned_v_i,
  input  returned_resp_s               returned_resp_i,
  output logic                         returned_ready_o,
  input  wire  [`VNI_X_CORD_WIDTH-1:0] tgo_x_i,
  input  wire  [`VNI_Y_CORD_WIDTH-1:0] tgo_y_i,
  input  wire  [`VNI_X_CORD_WIDTH-1:0] my_x_i,
  input  wire  [`VNI_Y_CORD_WIDTH-1:0] my_y_i,
  output logic                         ifetch_v_o,
  output logic [`VNI_DATA_WIDTH-1:0]   ifetch_instr_o,
  output logic                         float_resp_v_o,
  output load_resp_s                   float_resp_o,
  output logic                         int_resp_v_o,
  output load_resp_s                   int_resp_o,
  output logic                         int_resp_force_o,
  input  wire                          int_resp_yumi_i
);

  logic           req_ready;
  logic           req_v;
  remote_req_s    req_head;
  logic           req_yumi;
  logic           resp_v;
  returned_resp_s resp_head;
  logic           resp_full;
  logic           resp_yumi;
  credit_cnt_t    credits;

  // core sees a yumi when the request is taken
  assign remote_req_yumi_o = remote_req_v_i & req_ready;

  netif_fifo #(.payload_t(remote_req_s), .depth_p(`VNI_REQ_FIFO_DEPTH)) u_req_fifo (
    .clk_i, .reset_i, .v_i(remote_req_v_i), .data_i(remote_req_i), .ready_o(req_ready),
    .v_o(req_v), .data_o(req_head), .yumi_i(req_yumi), .full_o()
  );

  netif_fifo #(.payload_t(returned_resp_s), .depth_p(`VNI_RESP_FIFO_DEPTH)) u_resp_fifo (
    .clk_i, .reset_i, .v_i(returned_v_i), .data_i(returned_resp_i), .ready_o(returned_ready_o),
    .v_o(resp_v), .data_o(resp_head), .yumi_i(resp_yumi), .full_o(resp_full)
  );

  credit_counter u_credit_counter (
    .clk_i, .reset_i, .spend_i(req_yumi), .return_i(out_credit_v_i), .credits_o(credits)
  );

  network_tx u_network_tx (
    .clk_i, .reset_i, .req_v_i(req_v), .req_i(req_head), .req_yumi_o(req_yumi),
    .out_packet_o, .out_v_o, .out_ready_i, .credits_i(credits),
    .tgo_x_i, .tgo_y_i, .my_x_i, .my_y_i,
    .resp_v_i(resp_v), .resp_i(resp_head), .resp_full_i(resp_full), .resp_yumi_o(resp_yumi),
    .ifetch_v_o, .ifetch_instr_o, .float_resp_v_o, .float_resp_o,
    .int_resp_v_o, .int_resp_o, .int_resp_force_o, .int_resp_yumi_i
  );

endmodule

`default_nettype wire

/* tb/tb_vcore_netif.sv */
// vcore network interface testbench
`timescale 1ns/10ps
`default_nettype none

`include "vcore_netif_cfg.svh"

module tb_vcore_netif import vcore_netif_pkg::*; ();

  localparam int n_req_lp   = 13;
  localparam int n_resp_lp  = 15;
  localparam int n_burst_lp = `VNI_MAX_OUT_CREDITS + 2;
  localparam int n_rows_lp  = n_req_lp + n_burst_lp + n_resp_lp + `VNI_RESP_FIFO_DEPTH;
  localparam int timeout_lp = n_rows_lp * 40 + 200;
  localparam int to_ifetch_lp = 0;
  localparam int to_float_lp  = 1;
  localparam int to_int_lp    = 2;
  localparam logic [5:0]  my_x_lp  = 6'd3;
  localparam logic [4:0]  my_y_lp  = 5'd2;
  localparam logic [5:0]  tgo_x_lp = 6'd60;
  localparam logic [4:0]  tgo_y_lp = 5'd30;
  localparam logic [31:0] g_eva_lp = {2'b01, 6'd4, 6'd7, 16'h0100, 2'b00};
  localparam logic [31:0] word_lp  = 32'h9c80_7f35;

  logic           clk_i = 1'b0;
  logic           reset_i;
  logic           remote_req_v_i;
  remote_req_s    remote_req_i;
  logic           remote_req_yumi_o;
  netif_packet_s  out_packet_o;
  logic           out_v_o;
  logic           out_ready_i;
  logic           out_credit_v_i;
  logic           returned_v_i;
  returned_resp_s returned_resp_i;
  logic           returned_ready_o;
  logic [5:0]     tgo_x_i;
  logic [4:0]     tgo_y_i;
  logic [5:0]     my_x_i;
  logic [4:0]     my_y_i;
  logic           ifetch_v_o;
  logic [31:0]    ifetch_instr_o;
  logic           float_resp_v_o;
  load_resp_s     float_resp_o;
  logic           int_resp_v_o;
  load_resp_s     int_resp_o;
  logic           int_resp_force_o;
  logic           int_resp_yumi_i;

  // stimulus tables
  string         req_name [n_req_lp];
  remote_req_s   req_tab [n_req_lp];
  netif_packet_s pkt_tab [n_req_lp];
  string         resp_name [n_resp_lp];
  load_info_s    resp_info [n_resp_lp];
  logic [31:0]   resp_data [n_resp_lp];
  int            resp_cons [n_resp_lp];
  logic [31:0]   resp_val [n_resp_lp];
  int            n_req;
  int            n_resp;

  int            pkt_q [$];
  int            resp_q [$];
  integer        seed;
  logic [31:0]   rnd_ready;
  logic [31:0]   rnd_yumi;
  bit            ready_random;
  bit            ready_fixed;
  bit            yumi_random;
  bit            auto_credit;
  bit            force_seen;
  bit            held_v;
  netif_packet_s held_pkt;
  int            credit_due;
  int            acc_cnt;
  int            cycle_cnt;
  int            idx;
  int            nvalid;
  int            base;

  vcore_netif u_vcore_netif (.*);

  always #5 clk_i = ~clk_i;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_packet(input string name, input netif_packet_s exp,
                              input netif_packet_s act);
    if (act !== exp)
      stop_with_error($sformatf("ERR %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_load_resp(input string name, input load_resp_s exp, input load_resp_s act);
    if (act !== exp)
      stop_with_error($sformatf("ERR %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_instr(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      stop_with_error($sformatf("ERR %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic add_req(input string name, input logic [31:0] eva, input logic wnr,
                         input logic aq, input logic rl, input logic [3:0] mask,
                         input logic [31:0] payload, input packet_op_e op,
                         input logic [4:0] y, input logic [5:0] x, input logic [27:0] addr);
    req_name[n_req]                = name;
    req_tab[n_req].write_not_read  = wnr;
    req_tab[n_req].swap_aq         = aq;
    req_tab[n_req].swap_rl         = rl;
    req_tab[n_req].mask            = mask;
    req_tab[n_req].addr            = eva;
    req_tab[n_req].payload         = payload;
    pkt_tab[n_req].addr            = addr;
    pkt_tab[n_req].op              = op;
    pkt_tab[n_req].op_ex           = mask;
    pkt_tab[n_req].payload         = payload;
    pkt_tab[n_req].src_y_cord      = my_y_lp;
    pkt_tab[n_req].src_x_cord      = my_x_lp;
    pkt_tab[n_req].y_cord          = y;
    pkt_tab[n_req].x_cord          = x;
    n_req++;
  endtask

  function automatic load_info_s make_info(input logic fp, input logic icache, input logic uns,
                                           input logic byte_op, input logic hex_op,
                                           input logic [1:0] sel, input logic [4:0] rd);
    load_info_s li;
    li.float_wb       = fp;
    li.icache_fetch   = icache;
    li.is_unsigned_op = uns;
    li.is_byte_op     = byte_op;
    li.is_hex_op      = hex_op;
    li.part_sel       = sel;
    li.reg_id         = rd;
    return li;
  endfunction

  task automatic add_resp(input string name, input load_info_s info, input logic [31:0] data,
                          input int cons, input logic [31:0] val);
    resp_name[n_resp] = name;
    resp_info[n_resp] = info;
    resp_data[n_resp] = data;
    resp_cons[n_resp] = cons;
    resp_val[n_resp]  = val;
    n_resp++;
  endtask

  task automatic fill_tables();
    // dram, global and in-group translation with origin offset
    add_req("dram_load", {1'b1, 6'd5, 25'h001_2345}, 0, 0, 0, 4'hf, 32'h0000_0123,
            e_remote_load, 5'd31, 6'd5, 28'h001_2345);
    add_req("dram_store_top", {1'b1, 6'd63, 25'h1ff_ffff}, 1, 0, 0, 4'hf, 32'hcafe_f00d,
            e_remote_store, 5'd31, 6'd63, 28'h1ff_ffff);
    add_req("global_load", {2'b01, 6'd9, 6'd17, 16'hbeef, 2'b00}, 0, 0, 0, 4'hf, 32'h456,
            e_remote_load, 5'd9, 6'd17, 28'h000_beef);
    add_req("global_y_trunc", {2'b01, 6'd40, 6'd33, 16'h1234, 2'b10}, 1, 0, 0, 4'h3,
            32'h1357_9bdf, e_remote_store, 5'd8, 6'd33, 28'h000_1234);
    add_req("group_load", {3'b001, 5'd1, 6'd2, 16'h0042, 2'b00}, 0, 0, 0, 4'hf, 32'h789,
            e_remote_load, 5'd31, 6'd62, 28'h000_0042);
    add_req("group_wrap", {3'b001, 5'd5, 6'd10, 16'hf00d, 2'b01}, 1, 0, 0, 4'hc,
            32'h2468_ace0, e_remote_store, 5'd3, 6'd6, 28'h000_f00d);
    // op priority
    add_req("swap_aq", g_eva_lp, 0, 1, 0, 4'hf, 32'h1111_0007, e_remote_swap_aq, 5'd4, 6'd7, 28'h100);
    add_req("swap_rl", g_eva_lp, 0, 0, 1, 4'hf, 32'h2222_0008, e_remote_swap_rl, 5'd4, 6'd7, 28'h100);
    add_req("swap_aq_rl", g_eva_lp, 0, 1, 1, 4'h1, 32'h3333_0009, e_remote_swap_aq, 5'd4, 6'd7,
            28'h100);
    add_req("store_rl", g_eva_lp, 1, 0, 1, 4'h2, 32'h4444_000a, e_remote_swap_rl, 5'd4, 6'd7,
            28'h100);
    add_req("store_aq", g_eva_lp, 1, 1, 0, 4'h8, 32'h5555_000b, e_remote_swap_aq, 5'd4, 6'd7,
            28'h100);
    add_req("store_mask", g_eva_lp, 1, 0, 0, 4'b0101, 32'h6666_000c, e_remote_store, 5'd4, 6'd7,
            28'h100);
    add_req("load_mask0", g_eva_lp, 0, 0, 0, 4'h0, 32'h7777_000d, e_remote_load, 5'd4, 6'd7,
            28'h100);

    add_resp("ifetch", make_info(0, 1, 0, 0, 0, 0, 0), 32'h0001_2083, to_ifetch_lp, 32'h0001_2083);
    add_resp("float_lw", make_info(1, 0, 0, 0, 0, 0, 7), 32'h3f80_0000, to_float_lp, 32'h3f80_0000);
    add_resp("float_raw", make_info(1, 0, 0, 1, 0, 3, 12), word_lp, to_float_lp, word_lp);
    add_resp("lb_sel0", make_info(0, 0, 0, 1, 0, 0, 1), word_lp, to_int_lp, 32'h0000_0035);
    add_resp("lb_sel1", make_info(0, 0, 0, 1, 0, 1, 2), word_lp, to_int_lp, 32'h0000_007f);
    add_resp("lb_sel2", make_info(0, 0, 0, 1, 0, 2, 3), word_lp, to_int_lp, 32'hffff_ff80);
    add_resp("lb_sel3", make_info(0, 0, 0, 1, 0, 3, 4), word_lp, to_int_lp, 32'hffff_ff9c);
    add_resp("lbu_sel2", make_info(0, 0, 1, 1, 0, 2, 5), word_lp, to_int_lp, 32'h0000_0080);
    add_resp("lbu_sel3", make_info(0, 0, 1, 1, 0, 3, 6), word_lp, to_int_lp, 32'h0000_009c);
    add_resp("lh_sel0", make_info(0, 0, 0, 0, 1, 0, 8), word_lp, to_int_lp, 32'h0000_7f35);
    add_resp("lh_sel2", make_info(0, 0, 0, 0, 1, 2, 9), word_lp, to_int_lp, 32'hffff_9c80);
    add_resp("lhu_sel2", make_info(0, 0, 1, 0, 1, 2, 10), word_lp, to_int_lp, 32'h0000_9c80);
    add_resp("lh_sel3", make_info(0, 0, 0, 0, 1, 3, 13), word_lp, to_int_lp, 32'hffff_9c80);
    add_resp("lw", make_info(0, 0, 0, 0, 0, 0, 31), word_lp, to_int_lp, word_lp);
    add_resp("ifetch_2", make_info(0, 1, 0, 0, 0, 0, 0), 32'h00c5_8533, to_ifetch_lp,
             32'h00c5_8533);
  endtask

  // returns on the rising edge that takes the request
  task automatic push_req(input int i);
    remote_req_v_i <= 1'b1;
    remote_req_i   <= req_tab[i];
    pkt_q.push_back(i);
    @(negedge clk_i);
    while (!remote_req_yumi_o) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic push_resp(input int i);
    returned_v_i            <= 1'b1;
    returned_resp_i.data    <= resp_data[i];
    returned_resp_i.load_id <= resp_info[i];
    resp_q.push_back(i);
    @(negedge clk_i);
    while (!returned_ready_o) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic take_resp(input int cons);
    int         i;
    load_resp_s exp;
    if (resp_q.size() == 0) begin
      stop_with_error("a response was dispatched with none outstanding");
    end else begin
      i        = resp_q.pop_front();
      exp.rd   = resp_info[i].reg_id;
      exp.data = resp_val[i];
      if (cons != resp_cons[i])
        stop_with_error($sformatf("ERR %s: consumer expected %0d actual %0d",
                                  resp_name[i], resp_cons[i], cons));
      else if (cons == to_ifetch_lp) check_instr(resp_name[i], resp_val[i], ifetch_instr_o);
      else if (cons == to_float_lp) check_load_resp(resp_name[i], exp, float_resp_o);
      else check_load_resp(resp_name[i], exp, int_resp_o);
    end
  endtask

  // network side ready, credit returns and integer yumi
  always @(posedge clk_i) begin
    rnd_ready = $random(seed);
    rnd_yumi  = $random(seed);
    out_ready_i     <= ready_random ? rnd_ready[0] : ready_fixed;
    int_resp_yumi_i <= yumi_random ? rnd_yumi[0] : 1'b0;
    if (credit_due > 0) begin
      out_credit_v_i <= 1'b1;
      credit_due     = credit_due - 1;
    end else begin
      out_credit_v_i <= 1'b0;
    end
  end

  // packet monitor at the falling edge
  always @(negedge clk_i) begin
    if (!reset_i && out_v_o && out_ready_i) begin
      if (pkt_q.size() == 0) begin
        stop_with_error("a packet was accepted with none expected");
      end else begin
        idx = pkt_q.pop_front();
        check_packet(req_name[idx], pkt_tab[idx], out_packet_o);
        if (held_v) check_packet({req_name[idx], "_held"}, held_pkt, out_packet_o);
        held_v  = 1'b0;
        acc_cnt = acc_cnt + 1;
        if (auto_credit) credit_due = credit_due + 1;
      end
    end else if (!reset_i && out_v_o) begin
      if (held_v) check_packet("stalled_packet", held_pkt, out_packet_o);
      held_pkt = out_packet_o;
      held_v   = 1'b1;
    end
  end

  always @(negedge clk_i) begin
    if (!reset_i) begin
      nvalid = int'(ifetch_v_o) + int'(float_resp_v_o) + int'(int_resp_v_o);
      if (nvalid > 1) stop_with_error("more than one response consumer valid at once");
      if (int_resp_force_o && returned_ready_o)
        stop_with_error("int_resp_force_o high while the response FIFO is not full");
      if (ifetch_v_o) take_resp(to_ifetch_lp);
      else if (float_resp_v_o) take_resp(to_float_lp);
      else if (int_resp_v_o && (int_resp_yumi_i || int_resp_force_o)) take_resp(to_int_lp);
      if (int_resp_force_o) force_seen = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_lp)
      stop_with_error($sformatf("timeout after %0d cycles", cycle_cnt));
  end

  initial begin
    seed = 32'hb347_960f;
    n_req = 0;
    n_resp = 0;
    credit_due = 0;
    acc_cnt = 0;
    cycle_cnt = 0;
    held_v = 1'b0;
    force_seen = 1'b0;
    ready_random = 1'b0;
    ready_fixed = 1'b0;
    yumi_random = 1'b0;
    auto_credit = 1'b0;
    reset_i <= 1'b1;
    remote_req_v_i <= 1'b0;
    remote_req_i <= '0;
    out_ready_i <= 1'b0;
    out_credit_v_i <= 1'b0;
    returned_v_i <= 1'b0;
    returned_resp_i <= '0;
    int_resp_yumi_i <= 1'b0;
    tgo_x_i <= tgo_x_lp;
    tgo_y_i <= tgo_y_lp;
    my_x_i <= my_x_lp;
    my_y_i <= my_y_lp;
    fill_tables();
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (out_v_o || ifetch_v_o || float_resp_v_o || int_resp_v_o || int_resp_force_o)
      stop_with_error("a valid output is high right after reset");

    // translation and op encoding under random back-pressure
    ready_random = 1'b1;
    auto_credit = 1'b1;
    yumi_random = 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < n_req_lp; i++) push_req(i);
    remote_req_v_i <= 1'b0;
    while (pkt_q.size() != 0 || credit_due != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);

    // credits run out with no returns
    auto_credit = 1'b0;
    ready_random = 1'b0;
    ready_fixed = 1'b1;
    base = acc_cnt;
    @(posedge clk_i);
    for (int i = 0; i < n_burst_lp; i++) push_req(i % n_req_lp);
    remote_req_v_i <= 1'b0;
    while (acc_cnt != base + `VNI_MAX_OUT_CREDITS) @(negedge clk_i);
    repeat (20) begin
      @(negedge clk_i);
      if (out_v_o) stop_with_error("out_v_o high with no send credits left");
    end
    for (int k = 1; k <= 2; k++) begin
      credit_due = 1;
      while (acc_cnt != base + `VNI_MAX_OUT_CREDITS + k) @(negedge clk_i);
      repeat (10) begin
        @(negedge clk_i);
        if (out_v_o) stop_with_error("more than one packet sent for a single credit");
      end
    end

    // response dispatch with random integer yumi
    @(posedge clk_i);
    for (int i = 0; i < n_resp_lp; i++) push_resp(i);
    returned_v_i <= 1'b0;
    while (resp_q.size() != 0) @(negedge clk_i);

    // full queue forces integer responses out
    yumi_random = 1'b0;
    force_seen = 1'b0;
    @(posedge clk_i);
    for (int i = 3; i < 3 + `VNI_RESP_FIFO_DEPTH; i++) push_resp(i);
    returned_v_i <= 1'b0;
    while (!force_seen) @(negedge clk_i);
    yumi_random = 1'b1;
    while (resp_q.size() != 0) @(negedge clk_i);
    repeat (5) @(negedge clk_i);

    if (pkt_q.size() != 0 || resp_q.size() != 0 || acc_cnt != base + n_burst_lp) begin
      stop_with_error("packets or responses missing at the end of the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* vcore_netif.f */
+incdir+src
src/vcore_netif_pkg.sv
src/netif_fifo.sv
src/credit_counter.sv
src/load_packer.sv
src/network_tx.sv
src/vcore_netif.sv
tb/tb_vcore_netif.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f vcore_netif.f --top-module tb_vcore_netif &&
./obj_dir/Vtb_vcore_netif ||
{ echo "simulation run failed"; exit 1; }
